// ==== common/vde_pkg.sv ====
`default_nettype none

package vde_pkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int MAX_VARS = 256;
    localparam int IDX_W    = 9;
    localparam int ACT_W    = 32;
    localparam int VAR_W    = 32;

    // Heap slot contents with a 1-based var_id
    typedef struct packed {
        logic [ACT_W-1:0] score;
        logic [IDX_W-1:0] var_id;
    } heap_entry_t;

    typedef enum logic [3:0] {
        IDLE,
        INIT_LOOP,
        DECIDE,
        HIDE_READ_POS,
        HIDE_SWAP,
        HIDE_DOWN_READ,
        HIDE_DOWN_SWAP,
        UNHIDE_READ_POS,
        UNHIDE_SWAP,
        UP_READ,
        UP_SWAP,
        BUMP_READ,
        BUMP_UPDATE,
        RESCALE
    } heap_state_e;

    // ========================================
    // Activity constants
    // ========================================
    localparam logic [ACT_W-1:0] INITIAL_BUMP      = 32'd10000;
    localparam logic [ACT_W-1:0] RESCALE_THRESHOLD = {ACT_W{1'b1}} - 32'd1000000;
    localparam int               RESCALE_SHIFT     = 16;

endpackage

`default_nettype wire

// ==== common/heap_mem_if.sv ====
`default_nettype none

interface heap_mem_if;

    // Combinational read addresses
    logic [vde_pkg::IDX_W-1:0] idx;
    logic [vde_pkg::IDX_W-1:0] left;
    logic [vde_pkg::IDX_W-1:0] right;
    logic [vde_pkg::IDX_W-1:0] parent;

    vde_pkg::heap_entry_t      cur_entry;
    vde_pkg::heap_entry_t      left_entry;
    vde_pkg::heap_entry_t      right_entry;
    vde_pkg::heap_entry_t      parent_entry;
    // Phase hint of the variable at idx
    logic                      cur_phase;

    // Position lookup by 1-based variable number
    logic [vde_pkg::IDX_W-1:0] pos_var;
    logic [vde_pkg::IDX_W-1:0] pos_idx;

    // At most one write strobe per cycle
    logic                      swap_valid;
    logic [vde_pkg::IDX_W-1:0] swap_a;
    logic [vde_pkg::IDX_W-1:0] swap_b;
    logic                      add_valid;
    logic [vde_pkg::ACT_W-1:0] add_amount;
    logic                      shift_valid;
    logic                      init_valid;
    logic                      hint_valid;
    logic [vde_pkg::IDX_W-1:0] hint_var;
    logic                      hint_value;

    modport ctrl (
        output idx, left, right, parent, pos_var,
        output swap_valid, swap_a, swap_b, add_valid, add_amount,
        output shift_valid, init_valid, hint_valid, hint_var, hint_value,
        input  cur_entry, left_entry, right_entry, parent_entry, cur_phase, pos_idx
    );

    modport store (
        input  idx, left, right, parent, pos_var,
        input  swap_valid, swap_a, swap_b, add_valid, add_amount,
        input  shift_valid, init_valid, hint_valid, hint_var, hint_value,
        output cur_entry, left_entry, right_entry, parent_entry, cur_phase, pos_idx
    );

endinterface

`default_nettype wire

// ==== verilog/activity_scaler.sv ====
`default_nettype none

module activity_scaler (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      decay_step,
    input  logic                      rescale_done,
    output logic [vde_pkg::ACT_W-1:0] increment,
    output logic                      rescale_needed
);

    logic [vde_pkg::ACT_W:0]   grown;
    logic [vde_pkg::ACT_W-1:0] next_inc;

    // Grow by one sixteenth and saturate at all ones
    assign grown    = {1'b0, increment} + ({1'b0, increment} >> 4);
    assign next_inc = grown[vde_pkg::ACT_W] ? '1 : grown[vde_pkg::ACT_W-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            increment <= vde_pkg::INITIAL_BUMP;
        end else if (rescale_done) begin
            increment <= vde_pkg::INITIAL_BUMP;
        end else if (decay_step) begin
            increment <= next_inc;
        end
    end

    assign rescale_needed = (increment >= vde_pkg::RESCALE_THRESHOLD);

endmodule

`default_nettype wire

// ==== vde_heap/heap_store.sv ====
`default_nettype none

module heap_store (
    input  logic       clk,
    heap_mem_if.store  mem
);

    vde_pkg::heap_entry_t      heap  [vde_pkg::MAX_VARS];
    // Variable number minus one to heap index
    logic [vde_pkg::IDX_W-1:0] pos   [vde_pkg::MAX_VARS];
    logic                      phase [vde_pkg::MAX_VARS];

    vde_pkg::heap_entry_t      entry_a, entry_b, init_entry;

    // Heap slot from a heap index
    function automatic logic [vde_pkg::IDX_W-2:0] slot(input logic [vde_pkg::IDX_W-1:0] i);
        return i[vde_pkg::IDX_W-2:0];
    endfunction

    // Table slot from a 1-based variable number
    function automatic logic [vde_pkg::IDX_W-2:0] vslot(input logic [vde_pkg::IDX_W-1:0] v);
        logic [vde_pkg::IDX_W-1:0] s;
        s = v - 1'b1;
        return s[vde_pkg::IDX_W-2:0];
    endfunction

    // ========================================
    // Combinational reads
    // ========================================
    assign mem.cur_entry    = heap[slot(mem.idx)];
    assign mem.left_entry   = heap[slot(mem.left)];
    assign mem.right_entry  = heap[slot(mem.right)];
    assign mem.parent_entry = heap[slot(mem.parent)];
    assign mem.cur_phase    = phase[vslot(mem.cur_entry.var_id)];
    assign mem.pos_idx      = pos[vslot(mem.pos_var)];

    assign entry_a    = heap[slot(mem.swap_a)];
    assign entry_b    = heap[slot(mem.swap_b)];
    assign init_entry = '{score: '0, var_id: mem.idx + 1'b1};

    // ========================================
    // Strobed writes
    // ========================================
    always_ff @(posedge clk) begin
        // Positions follow the entries so pos[] stays the inverse of heap[]
        if (mem.swap_valid) begin
            heap[slot(mem.swap_a)]     <= entry_b;
            heap[slot(mem.swap_b)]     <= entry_a;
            pos[vslot(entry_b.var_id)] <= mem.swap_a;
            pos[vslot(entry_a.var_id)] <= mem.swap_b;
        end
        if (mem.add_valid) begin
            heap[slot(mem.idx)].score <= mem.cur_entry.score + mem.add_amount;
        end
        if (mem.shift_valid) begin
            heap[slot(mem.idx)].score <= mem.cur_entry.score >> vde_pkg::RESCALE_SHIFT;
        end
        if (mem.init_valid) begin
            heap[slot(mem.idx)]  <= init_entry;
            pos[slot(mem.idx)]   <= mem.idx;
            phase[slot(mem.idx)] <= 1'b0;
        end
        if (mem.hint_valid) begin
            phase[vslot(mem.hint_var)] <= mem.hint_value;
        end
    end

    assert property (@(posedge clk)
        $onehot0({mem.swap_valid, mem.add_valid, mem.shift_valid,
                  mem.init_valid, mem.hint_valid}));

endmodule

`default_nettype wire

// ==== vde_heap/heap_control.sv ====
`default_nettype none

module heap_control (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      request,
    input  logic                      clear_all,
    input  logic [vde_pkg::VAR_W-1:0] max_var,
    input  logic                      assign_valid,
    input  logic [vde_pkg::VAR_W-1:0] assign_var,
    input  logic                      assign_value,
    input  logic                      clear_valid,
    input  logic [vde_pkg::VAR_W-1:0] clear_var,
    input  logic                      bump_valid,
    input  logic [vde_pkg::VAR_W-1:0] bump_var,
    input  logic                      decay,
    input  logic [vde_pkg::ACT_W-1:0] increment,
    input  logic                      rescale_needed,
    heap_mem_if.ctrl                  mem,
    output logic                      decay_step,
    output logic                      rescale_done,
    output logic                      decision_valid,
    output logic [vde_pkg::VAR_W-1:0] decision_var,
    output logic                      decision_phase,
    output logic                      all_assigned,
    output logic                      busy
);

    vde_pkg::heap_state_e      state_q, state_d;
    logic [vde_pkg::IDX_W-1:0] heap_size_q, heap_size_d;
    logic [vde_pkg::IDX_W-1:0] idx_q, idx_d;
    logic [vde_pkg::IDX_W-1:0] pend_var_q, pend_var_d;
    logic                      pend_value_q, pend_value_d;

    logic                      max_ok;
    logic [vde_pkg::IDX_W-1:0] nvars;
    logic [vde_pkg::VAR_W-1:0] var_lim;
    logic                      assign_ok, clear_ok, bump_ok;
    logic [vde_pkg::IDX_W:0]   left_full, right_full, size_ext;
    logic [vde_pkg::IDX_W-1:0] parent_idx, best_idx;
    vde_pkg::heap_entry_t      best_entry;
    logic                      go_down, go_up;

    // Higher score wins, lower var_id breaks ties
    function automatic logic better(input vde_pkg::heap_entry_t a,
                                    input vde_pkg::heap_entry_t b);
        return (a.score > b.score) || ((a.score == b.score) && (a.var_id < b.var_id));
    endfunction

    // ========================================
    // Command range checks
    // ========================================
    assign max_ok  = (max_var != '0) && (max_var <= vde_pkg::MAX_VARS);
    assign nvars   = max_ok ? max_var[vde_pkg::IDX_W-1:0] : '0;
    assign var_lim = {{(vde_pkg::VAR_W - vde_pkg::IDX_W){1'b0}}, nvars};

    assign assign_ok = assign_valid && (assign_var != '0) && (assign_var <= var_lim);
    assign clear_ok  = clear_valid && (clear_var != '0) && (clear_var <= var_lim);
    assign bump_ok   = bump_valid && (bump_var != '0) && (bump_var <= var_lim);

    // ========================================
    // Sift comparisons
    // ========================================
    assign left_full  = {idx_q, 1'b1};
    assign right_full = left_full + 1'b1;
    assign size_ext   = {1'b0, heap_size_q};
    // Wraps at the root where go_up masks it
    assign parent_idx = (idx_q - 1'b1) >> 1;

    always_comb begin
        best_idx   = idx_q;
        best_entry = mem.cur_entry;
        if ((left_full < size_ext) && better(mem.left_entry, best_entry)) begin
            best_idx   = left_full[vde_pkg::IDX_W-1:0];
            best_entry = mem.left_entry;
        end
        if ((right_full < size_ext) && better(mem.right_entry, best_entry)) begin
            best_idx = right_full[vde_pkg::IDX_W-1:0];
        end
    end

    assign go_down = (best_idx != idx_q);
    assign go_up   = (idx_q != '0) && better(mem.cur_entry, mem.parent_entry);

    assign mem.idx        = idx_q;
    assign mem.left       = left_full[vde_pkg::IDX_W-1:0];
    assign mem.right      = right_full[vde_pkg::IDX_W-1:0];
    assign mem.parent     = parent_idx;
    assign mem.pos_var    = pend_var_q;
    assign mem.swap_a     = idx_q;
    assign mem.add_amount = increment;
    assign mem.hint_var   = pend_var_q;
    assign mem.hint_value = pend_value_q;

    // ========================================
    // Next state
    // ========================================
    always_comb begin
        state_d         = state_q;
        heap_size_d     = heap_size_q;
        idx_d           = idx_q;
        pend_var_d      = pend_var_q;
        pend_value_d    = pend_value_q;
        mem.swap_valid  = 1'b0;
        mem.swap_b      = best_idx;
        mem.add_valid   = 1'b0;
        mem.shift_valid = 1'b0;
        mem.init_valid  = 1'b0;
        mem.hint_valid  = 1'b0;
        decay_step      = 1'b0;
        rescale_done    = 1'b0;
        decision_valid  = 1'b0;
        all_assigned    = 1'b0;

        case (state_q)
            vde_pkg::IDLE: begin
                if (assign_ok) begin
                    pend_var_d   = assign_var[vde_pkg::IDX_W-1:0];
                    pend_value_d = assign_value;
                    state_d      = vde_pkg::HIDE_READ_POS;
                end else if (clear_ok) begin
                    pend_var_d = clear_var[vde_pkg::IDX_W-1:0];
                    state_d    = vde_pkg::UNHIDE_READ_POS;
                end else if (bump_ok) begin
                    pend_var_d = bump_var[vde_pkg::IDX_W-1:0];
                    state_d    = vde_pkg::BUMP_READ;
                end else if (request) begin
                    idx_d   = '0;
                    state_d = vde_pkg::DECIDE;
                end else if (decay) begin
                    // RESCALE exits at once unless the new increment is too large
                    decay_step = 1'b1;
                    idx_d      = '0;
                    state_d    = vde_pkg::RESCALE;
                end
            end

            vde_pkg::DECIDE: begin
                all_assigned   = (heap_size_q == '0);
                decision_valid = (heap_size_q != '0);
                if (!request) begin
                    state_d = vde_pkg::IDLE;
                end
            end

            // Hide moves the variable to the last active slot and shrinks the heap
            vde_pkg::HIDE_READ_POS: begin
                mem.hint_valid = 1'b1;
                idx_d          = mem.pos_idx;
                state_d = (mem.pos_idx < heap_size_q) ? vde_pkg::HIDE_SWAP : vde_pkg::IDLE;
            end

            vde_pkg::HIDE_SWAP: begin
                mem.swap_valid = 1'b1;
                mem.swap_b     = heap_size_q - 1'b1;
                heap_size_d    = heap_size_q - 1'b1;
                state_d = (idx_q < heap_size_q - 1'b1) ? vde_pkg::HIDE_DOWN_READ : vde_pkg::IDLE;
            end

            vde_pkg::HIDE_DOWN_READ: begin
                state_d = go_down ? vde_pkg::HIDE_DOWN_SWAP : vde_pkg::IDLE;
            end

            vde_pkg::HIDE_DOWN_SWAP: begin
                mem.swap_valid = 1'b1;
                mem.swap_b     = best_idx;
                idx_d          = best_idx;
                state_d        = vde_pkg::HIDE_DOWN_READ;
            end

            // Unhide pulls the variable to the first free slot and grows the heap
            vde_pkg::UNHIDE_READ_POS: begin
                idx_d   = mem.pos_idx;
                state_d = (mem.pos_idx >= heap_size_q) ? vde_pkg::UNHIDE_SWAP : vde_pkg::IDLE;
            end

            vde_pkg::UNHIDE_SWAP: begin
                mem.swap_valid = 1'b1;
                mem.swap_b     = heap_size_q;
                heap_size_d    = heap_size_q + 1'b1;
                idx_d          = heap_size_q;
                state_d        = vde_pkg::UP_READ;
            end

            vde_pkg::UP_READ: begin
                state_d = go_up ? vde_pkg::UP_SWAP : vde_pkg::IDLE;
            end

            vde_pkg::UP_SWAP: begin
                mem.swap_valid = 1'b1;
                mem.swap_b     = parent_idx;
                idx_d          = parent_idx;
                state_d        = vde_pkg::UP_READ;
            end

            vde_pkg::BUMP_READ: begin
                idx_d   = mem.pos_idx;
                state_d = vde_pkg::BUMP_UPDATE;
            end

            // Hidden variables keep their score but need no sift
            vde_pkg::BUMP_UPDATE: begin
                mem.add_valid = 1'b1;
                state_d = (idx_q < heap_size_q) ? vde_pkg::UP_READ : vde_pkg::IDLE;
            end

            vde_pkg::INIT_LOOP: begin
                mem.init_valid = 1'b1;
                idx_d          = idx_q + 1'b1;
                if (int'(idx_q) == vde_pkg::MAX_VARS - 1) begin
                    state_d = vde_pkg::IDLE;
                end
            end

            vde_pkg::RESCALE: begin
                if (!rescale_needed) begin
                    state_d = vde_pkg::IDLE;
                end else if (idx_q < nvars) begin
                    mem.shift_valid = 1'b1;
                    idx_d           = idx_q + 1'b1;
                end else begin
                    rescale_done = 1'b1;
                    state_d      = vde_pkg::IDLE;
                end
            end

            default: state_d = vde_pkg::IDLE;
        endcase

        // clear_all restarts from any state and also resets the increment
        if (clear_all) begin
            state_d      = vde_pkg::INIT_LOOP;
            heap_size_d  = nvars;
            idx_d        = '0;
            rescale_done = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q      <= vde_pkg::IDLE;
            heap_size_q  <= '0;
            idx_q        <= '0;
            pend_var_q   <= '0;
            pend_value_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            heap_size_q  <= heap_size_d;
            idx_q        <= idx_d;
            pend_var_q   <= pend_var_d;
            pend_value_q <= pend_value_d;
        end
    end

    assign busy           = (state_q != vde_pkg::IDLE);
    assign decision_var   = decision_valid ?
                            {{(vde_pkg::VAR_W - vde_pkg::IDX_W){1'b0}}, mem.cur_entry.var_id} :
                            '0;
    assign decision_phase = decision_valid && mem.cur_phase;

    // ========================================
    // Assertions
    // ========================================
    assert property (@(posedge clk) disable iff (reset)
        int'(heap_size_q) <= vde_pkg::MAX_VARS);

    assert property (@(posedge clk) disable iff (reset)
        !(decision_valid && all_assigned));

    // A decay that crosses the threshold never returns to IDLE unscaled
    assert property (@(posedge clk) disable iff (reset)
        (state_q == vde_pkg::IDLE) |-> (increment < vde_pkg::RESCALE_THRESHOLD));

endmodule

`default_nettype wire

// ==== vde_heap/vde_heap.sv ====
`default_nettype none

module vde_heap (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      request,
    input  logic                      clear_all,
    input  logic [vde_pkg::VAR_W-1:0] max_var,
    input  logic                      assign_valid,
    input  logic [vde_pkg::VAR_W-1:0] assign_var,
    input  logic                      assign_value,
    input  logic                      clear_valid,
    input  logic [vde_pkg::VAR_W-1:0] clear_var,
    input  logic                      bump_valid,
    input  logic [vde_pkg::VAR_W-1:0] bump_var,
    input  logic                      decay,
    output logic                      decision_valid,
    output logic [vde_pkg::VAR_W-1:0] decision_var,
    output logic                      decision_phase,
    output logic                      all_assigned,
    output logic                      busy
);

    // Scaler handshake
    logic [vde_pkg::ACT_W-1:0] increment;
    logic                      rescale_needed;
    logic                      decay_step;
    logic                      rescale_done;

    heap_mem_if mem_bus ();

    heap_control i_heap_control (
        .clk            (clk),
        .reset          (reset),
        .request        (request),
        .clear_all      (clear_all),
        .max_var        (max_var),
        .assign_valid   (assign_valid),
        .assign_var     (assign_var),
        .assign_value   (assign_value),
        .clear_valid    (clear_valid),
        .clear_var      (clear_var),
        .bump_valid     (bump_valid),
        .bump_var       (bump_var),
        .decay          (decay),
        .increment      (increment),
        .rescale_needed (rescale_needed),
        .mem            (mem_bus),
        .decay_step     (decay_step),
        .rescale_done   (rescale_done),
        .decision_valid (decision_valid),
        .decision_var   (decision_var),
        .decision_phase (decision_phase),
        .all_assigned   (all_assigned),
        .busy           (busy)
    );

    heap_store i_heap_store (
        .clk (clk),
        .mem (mem_bus)
    );

    activity_scaler i_activity_scaler (
        .clk            (clk),
        .reset          (reset),
        .decay_step     (decay_step),
        .rescale_done   (rescale_done),
        .increment      (increment),
        .rescale_needed (rescale_needed)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_vde_heap.sv ====
`default_nettype none

module tb_vde_heap;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_TESTS       = 6;
    localparam int MAX_DECAY_STEPS = 400;
    localparam int IDLE_WAIT_LIMIT = 2 * vde_pkg::MAX_VARS;
    // Generous per-test budget plus decay steps and the init loops
    localparam int TIMEOUT_CYCLES  = NUM_TESTS * 400 + MAX_DECAY_STEPS * 20
                                     + 3 * vde_pkg::MAX_VARS;

    logic                      clk;
    logic                      reset;
    logic                      request;
    logic                      clear_all;
    logic [vde_pkg::VAR_W-1:0] max_var;
    logic                      assign_valid;
    logic [vde_pkg::VAR_W-1:0] assign_var;
    logic                      assign_value;
    logic                      clear_valid;
    logic [vde_pkg::VAR_W-1:0] clear_var;
    logic                      bump_valid;
    logic [vde_pkg::VAR_W-1:0] bump_var;
    logic                      decay;
    logic                      decision_valid;
    logic [vde_pkg::VAR_W-1:0] decision_var;
    logic                      decision_phase;
    logic                      all_assigned;
    logic                      busy;

    // Reference model of scores, active set and phase hints
    logic [vde_pkg::ACT_W-1:0] model_score  [1:vde_pkg::MAX_VARS];
    bit                        model_active [1:vde_pkg::MAX_VARS];
    bit                        model_phase  [1:vde_pkg::MAX_VARS];
    logic [vde_pkg::ACT_W-1:0] model_inc;
    int                        model_nvars;

    int errors;
    int checks;
    int tests_run;
    int tests_failed;

    vde_heap i_vde_heap (
        .clk            (clk),
        .reset          (reset),
        .request        (request),
        .clear_all      (clear_all),
        .max_var        (max_var),
        .assign_valid   (assign_valid),
        .assign_var     (assign_var),
        .assign_value   (assign_value),
        .clear_valid    (clear_valid),
        .clear_var      (clear_var),
        .bump_valid     (bump_valid),
        .bump_var       (bump_var),
        .decay          (decay),
        .decision_valid (decision_valid),
        .decision_var   (decision_var),
        .decision_phase (decision_phase),
        .all_assigned   (all_assigned),
        .busy           (busy)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ========================================
    // Model
    // ========================================
    function automatic bit in_range(input int v);
        return (v >= 1) && (v <= model_nvars);
    endfunction

    function automatic void model_reset(input int n);
        model_nvars = n;
        model_inc   = vde_pkg::INITIAL_BUMP;
        for (int v = 1; v <= vde_pkg::MAX_VARS; v++) begin
            model_score[v]  = '0;
            model_active[v] = (v <= n);
            model_phase[v]  = 1'b0;
        end
    endfunction

    // Highest scoring active variable with the lowest id on a tie, or 0 if none
    function automatic int expected_top();
        int best;
        best = 0;
        for (int v = 1; v <= model_nvars; v++) begin
            if (model_active[v] && (best == 0 || model_score[v] > model_score[best])) begin
                best = v;
            end
        end
        return best;
    endfunction

    // Grow by a sixteenth and rescale once past the threshold
    function automatic bit model_decay();
        longint unsigned next_inc;
        next_inc = longint'(model_inc) + longint'(model_inc >> 4);
        if (next_inc > 64'h0000_0000_FFFF_FFFF) begin
            next_inc = 64'h0000_0000_FFFF_FFFF;
        end
        model_inc = next_inc[31:0];
        if (model_inc >= vde_pkg::RESCALE_THRESHOLD) begin
            for (int v = 1; v <= model_nvars; v++) begin
                model_score[v] = model_score[v] >> vde_pkg::RESCALE_SHIFT;
            end
            model_inc = vde_pkg::INITIAL_BUMP;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // ========================================
    // Drivers and checks
    // ========================================
    task automatic check(input string what, input logic [31:0] got,
                         input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s, got %0d, expected %0d",
                     $time, what, got, expected);
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy && cycles < IDLE_WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (busy) begin
            errors++;
            $display("Timeout at %0t: busy stayed high for %0d cycles", $time, cycles);
        end
    endtask

    task automatic do_clear_all(input int n);
        wait_idle();
        max_var   = n;
        clear_all = 1'b1;
        @(posedge clk);
        #1;
        clear_all = 1'b0;
        model_reset(n);
    endtask

    task automatic do_assign(input int v, input logic value);
        wait_idle();
        assign_valid = 1'b1;
        assign_var   = v;
        assign_value = value;
        @(posedge clk);
        #1;
        assign_valid = 1'b0;
        if (in_range(v)) begin
            model_active[v] = 1'b0;
            model_phase[v]  = value;
        end
    endtask

    task automatic do_clear(input int v);
        wait_idle();
        clear_valid = 1'b1;
        clear_var   = v;
        @(posedge clk);
        #1;
        clear_valid = 1'b0;
        if (in_range(v)) begin
            model_active[v] = 1'b1;
        end
    endtask

    task automatic do_bump(input int v);
        wait_idle();
        bump_valid = 1'b1;
        bump_var   = v;
        @(posedge clk);
        #1;
        bump_valid = 1'b0;
        if (in_range(v)) begin
            model_score[v] = model_score[v] + model_inc;
        end
    endtask

    task automatic do_decay(output bit rescaled);
        wait_idle();
        decay = 1'b1;
        @(posedge clk);
        #1;
        decay    = 1'b0;
        rescaled = model_decay();
    endtask

    // Holds request for one DECIDE cycle and compares with the model
    task automatic decide_and_check(input string what);
        logic                      valid;
        logic                      phase;
        logic                      none_left;
        logic [vde_pkg::VAR_W-1:0] dvar;
        int                        exp_var;
        wait_idle();
        request = 1'b1;
        @(posedge clk);
        #1;
        valid     = decision_valid;
        dvar      = decision_var;
        phase     = decision_phase;
        none_left = all_assigned;
        request   = 1'b0;
        @(posedge clk);
        #1;
        exp_var = expected_top();
        if (exp_var == 0) begin
            check({what, ": decision_valid"}, 32'(valid), 32'd0);
            check({what, ": all_assigned"}, 32'(none_left), 32'd1);
        end else begin
            check({what, ": decision_valid"}, 32'(valid), 32'd1);
            check({what, ": all_assigned"}, 32'(none_left), 32'd0);
            check({what, ": decision_var"}, dvar, exp_var);
            check({what, ": decision_phase"}, 32'(phase), 32'(model_phase[exp_var]));
        end
    endtask

    task automatic finish_test(input int num, input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAILED with %0d errors", num, name, errors - errors_before);
        end
    endtask

    // ========================================
    // Tests
    // ========================================
    task automatic test_init_order();
        int errs_at_start;
        errs_at_start = errors;
        do_clear_all(10);
        decide_and_check("decide after init");
        finish_test(1, "init order", errs_at_start);
    endtask

    task automatic test_hide_exhaust();
        int errs_at_start;
        errs_at_start = errors;
        do_assign(1, 1'b1);
        decide_and_check("decide after hiding var 1");
        for (int v = 2; v <= 10; v++) begin
            do_assign(v, (v % 2) == 1);
        end
        decide_and_check("decide with all hidden");
        finish_test(2, "hide and exhaustion", errs_at_start);
    endtask

    task automatic test_unhide_phase();
        int errs_at_start;
        errs_at_start = errors;
        do_clear(1);
        do_clear(4);
        decide_and_check("decide after unhide");
        finish_test(3, "unhide phase hint", errs_at_start);
    endtask

    task automatic test_bump_decay();
        int errs_at_start;
        bit rescaled;
        errs_at_start = errors;
        do_clear_all(10);
        do_bump(5);
        decide_and_check("decide after bump 5");
        do_bump(3);
        decide_and_check("decide after bump 3");
        do_decay(rescaled);
        do_bump(7);
        decide_and_check("decide after decay and bump 7");
        finish_test(4, "bump ordering and decay", errs_at_start);
    endtask

    task automatic test_out_of_range();
        int errs_at_start;
        errs_at_start = errors;
        do_assign(0, 1'b1);
        check("busy after assign of var 0", 32'(busy), 32'd0);
        do_bump(11);
        check("busy after bump of var 11", 32'(busy), 32'd0);
        decide_and_check("decide after ignored commands");
        finish_test(5, "out of range commands", errs_at_start);
    endtask

    task automatic test_rescale();
        int errs_at_start;
        int steps;
        bit rescaled;
        errs_at_start = errors;
        do_bump(2);
        decide_and_check("decide after bump 2");
        steps    = 0;
        rescaled = 1'b0;
        while (!rescaled && steps < MAX_DECAY_STEPS) begin
            do_decay(rescaled);
            steps++;
        end
        if (!rescaled) begin
            errors++;
            $display("Increment did not reach the rescale threshold in %0d decays", steps);
        end
        do_bump(9);
        decide_and_check("decide after rescale and bump 9");
        finish_test(6, "rescale", errs_at_start);
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        request      = 1'b0;
        clear_all    = 1'b0;
        max_var      = '0;
        assign_valid = 1'b0;
        assign_var   = '0;
        assign_value = 1'b0;
        clear_valid  = 1'b0;
        clear_var    = '0;
        bump_valid   = 1'b0;
        bump_var     = '0;
        decay        = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        model_reset(0);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        test_init_order();
        test_hide_exhaust();
        test_unhide_phase();
        test_bump_decay();
        test_out_of_range();
        test_rescale();

        $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/vde_pkg.sv
common/heap_mem_if.sv
verilog/activity_scaler.sv
vde_heap/heap_store.sv
vde_heap/heap_control.sv
vde_heap/vde_heap.sv
testbench/tb_vde_heap.sv

// ==== Makefile ====
TOP = tb_vde_heap

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

# Pass is decided by the pass line in the simulation output
sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx 'Testbench passed'

clean:
	rm -rf obj_dir
